/* flist.f */
src/rs_pkg.sv
src/rs_entry_array.sv
src/issue_select.sv
src/int_alu.sv
src/issue_unit.sv
bench/issue_unit_assert.sv
bench/tb_issue_unit.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_issue_unit \
    -f flist.f \
    -o tb_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1

grep -qx "Testbench passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* bench/tb_issue_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_issue_unit import rs_pkg::*; ();

    localparam logic [31:0] seed        = 32'hb8b2909b;
    localparam int          cycle_limit = 4000;
    localparam logic [5:0]  dead_tag    = 6'd63;   // never used as a destination

    logic      clk;
    logic      reset;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      rs_full;
    logic      result_valid;
    result_t   result;

    logic [31:0]       lfsr_q;
    logic [data_w-1:0] exp_val [64];
    logic [63:0]       known;
    logic [63:0]       pending;   // dispatched, result not yet seen
    logic [5:0]        tag_order [$];
    logic [5:0]        next_tag;
    int                err_count;
    int                cycle_count;
    int                tests_done;

    issue_unit #(
        .rs_depth(16)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .dispatch_valid(dispatch_valid),
        .dispatch      (dispatch),
        .rs_full       (rs_full),
        .result_valid  (result_valid),
        .result        (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [data_w-1:0] alu_model(
        input alu_op_e           op,
        input logic [data_w-1:0] a,
        input logic [data_w-1:0] b
    );
        case (op)
            add:     return a + b;
            sub:     return a - b;
            and_op:  return a & b;
            or_op:   return a | b;
            xor_op:  return a ^ b;
            sll:     return a << b[4:0];
            srl:     return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;   // slt
        endcase
    endfunction

    function automatic src_operand_t ready_src(input logic [data_w-1:0] v);
        return '{ready: 1'b1, tag: 6'd0, data: v};
    endfunction

    function automatic src_operand_t wait_src(input logic [5:0] t);
        return '{ready: 1'b0, tag: t, data: 32'd0};
    endfunction

    // next tag not in flight, like a free list
    function automatic logic [5:0] alloc_tag();
        logic [5:0] t;
        t = next_tag;
        while (pending[t] || t == dead_tag) begin
            t = t + 6'd1;
        end
        next_tag = t + 6'd1;
        return t;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_slot();
        while (rs_full) begin
            idle(1);
        end
    endtask

    task automatic wait_drain();
        while (pending != '0) begin
            idle(1);
        end
    endtask

    // returns in the cycle the tag is on the result bus
    task automatic wait_result(input logic [5:0] t);
        while (!(result_valid && result.tag == t)) begin
            idle(1);
        end
    endtask

    // one-cycle strobe, model updated at the same time
    task automatic drive_dispatch(
        input alu_op_e      op,
        input logic [5:0]   d,
        input src_operand_t s1,
        input src_operand_t s2
    );
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        a = s1.ready ? s1.data : exp_val[s1.tag];
        b = s2.ready ? s2.data : exp_val[s2.tag];
        known[d]       = (s1.ready || known[s1.tag]) && (s2.ready || known[s2.tag]);
        exp_val[d]     = alu_model(op, a, b);
        pending[d]     = 1'b1;
        dispatch       = '{op: op, dest: d, src1: s1, src2: s2};
        dispatch_valid = 1'b1;
        idle(1);
        dispatch_valid = 1'b0;
    endtask

    task automatic report(input string name, input int errs_before);
        tests_done++;
        $display("test %0d %s finished, %0d new errors", tests_done, name,
                 err_count - errs_before);
    endtask

    // result bus checked mid-cycle where it is stable
    always @(negedge clk) begin
        if (!reset && result_valid) begin
            assert (pending[result.tag]) else begin
                $display("result with tag %0d that is not in flight", result.tag);
                err_count++;
            end
            if (pending[result.tag] && known[result.tag]) begin
                assert (result.value == exp_val[result.tag]) else begin
                    $display("FAIL result.value got %h expected %h", result.value,
                             exp_val[result.tag]);
                    err_count++;
                end
            end
            if (tag_order.size() != 0) begin
                assert (result.tag == tag_order[0]) else begin
                    $display("FAIL result.tag got %h expected %h", result.tag, tag_order[0]);
                    err_count++;
                end
                void'(tag_order.pop_front());
            end
            pending[result.tag] = 1'b0;
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= cycle_limit) begin
                $display("timeout after %0d cycles, results never drained", cycle_count);
                $display("Testbench failed");
                $finish;
            end
        end
    end

    initial begin
        logic [5:0]        d;
        logic [5:0]        x;
        logic [5:0]        lastd;
        logic [31:0]       r;
        logic [data_w-1:0] pa;
        logic [data_w-1:0] pb;
        src_operand_t      s1;
        src_operand_t      s2;
        int                e0;
        int                total;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        lfsr_q         = seed;
        known          = '0;
        pending        = '0;
        next_tag       = 6'd0;
        err_count      = 0;
        tests_done     = 0;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        e0 = err_count;
        repeat (10) begin
            assert (!rs_full && !result_valid) else begin
                $display("rs_full or result_valid high after reset with no dispatch");
                err_count++;
            end
            idle(1);
        end
        report("reset", e0);

        e0 = err_count;
        for (int i = 0; i < 8; i++) begin
            drive_dispatch(alu_op_e'(i[2:0]), alloc_tag(), ready_src(rand_bits(32)),
                           ready_src(rand_bits(32)));
            wait_drain();
        end
        report("independent opcodes", e0);

        e0 = err_count;
        lastd = alloc_tag();
        tag_order.push_back(lastd);
        drive_dispatch(add, lastd, ready_src(rand_bits(32)), ready_src(rand_bits(32)));
        for (int i = 1; i < 8; i++) begin
            d = alloc_tag();
            tag_order.push_back(d);
            if (i % 2 == 0) begin
                wait_result(lastd);   // next dispatch meets the result on the bus
            end
            drive_dispatch(alu_op_e'(rand_bits(3)), d, wait_src(lastd), ready_src(rand_bits(32)));
            lastd = d;
        end
        wait_drain();
        report("dependent chain", e0);

        e0 = err_count;
        x  = alloc_tag();
        pa = rand_bits(32);
        pb = rand_bits(32);
        pending[x] = 1'b1;
        known[x]   = 1'b1;
        exp_val[x] = alu_model(xor_op, pa, pb);
        tag_order.push_back(x);
        for (int i = 0; i < 4; i++) begin
            d = alloc_tag();
            tag_order.push_back(d);
            drive_dispatch(alu_op_e'(rand_bits(3)), d, ready_src(rand_bits(32)), wait_src(x));
        end
        drive_dispatch(xor_op, x, ready_src(pa), ready_src(pb));
        wait_drain();
        report("priority", e0);

        e0 = err_count;
        for (int i = 0; i < 16; i++) begin
            drive_dispatch(or_op, alloc_tag(), wait_src(dead_tag), ready_src(rand_bits(32)));
        end
        repeat (5) begin
            assert (rs_full) else begin
                $display("rs_full low with all 16 slots occupied");
                err_count++;
            end
            idle(1);
        end
        reset = 1'b1;
        idle(2);
        pending = '0;
        known   = '0;
        reset   = 1'b0;
        assert (!rs_full) else begin
            $display("rs_full still high after reset");
            err_count++;
        end
        report("full indication", e0);

        e0 = err_count;
        lastd = dead_tag;
        for (int i = 0; i < 200; i++) begin
            wait_slot();
            r  = rand_bits(3);
            s1 = (pending[lastd] && r[0]) ? wait_src(lastd) : ready_src(rand_bits(32));
            s2 = (pending[lastd] && r[2:1] == 2'b11) ? wait_src(lastd)
                                                     : ready_src(rand_bits(32));
            d  = alloc_tag();
            drive_dispatch(alu_op_e'(rand_bits(3)), d, s1, s2);
            lastd = d;
            if (rand_bits(2) == 32'd0) begin
                idle(1);
            end
        end
        wait_drain();
        report("random uniqueness", e0);

        idle(3);
        total = err_count + int'(i_dut.u_chk.any_fail);
        $display("%0d tests, %0d testbench errors, assertion failure flag %0d", tests_done,
                 err_count, i_dut.u_chk.any_fail);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/issue_unit_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_unit_assert import rs_pkg::*; #(
    parameter int rs_depth = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                dispatch_valid,
    input  dispatch_t           dispatch,
    input  logic                rs_full,
    input  logic [rs_depth-1:0] free_vec,
    input  logic                result_valid,
    input  result_t             result
);

    logic fail_strobe = 1'b0;
    logic fail_fast   = 1'b0;
    logic fail_reset  = 1'b0;
    logic any_fail;

    assign any_fail = fail_strobe | fail_fast | fail_reset;

    // outside must hold off while full
    no_dispatch_full: assert property (@(posedge clk) disable iff (reset)
        dispatch_valid |-> !rs_full)
        else begin $error("dispatch while station full"); fail_strobe = 1'b1; end

    // result registered two edges after dispatch, sampled one edge later
    fast_path: assert property (@(posedge clk) disable iff (reset)
        (dispatch_valid && dispatch.src1.ready && dispatch.src2.ready && (&free_vec))
        |-> ##3 (result_valid && result.tag == $past(dispatch.dest, 3)))
        else begin $error("ready dispatch missed two-edge result"); fail_fast = 1'b1; end

    reset_quiet: assert property (@(posedge clk)
        $fell(reset) |-> (!rs_full && !result_valid))
        else begin $error("outputs active right after reset"); fail_reset = 1'b1; end

endmodule

bind issue_unit issue_unit_assert #(
    .rs_depth(rs_depth)
) u_chk (
    .clk           (clk),
    .reset         (reset),
    .dispatch_valid(dispatch_valid),
    .dispatch      (dispatch),
    .rs_full       (rs_full),
    .free_vec      (free_vec),
    .result_valid  (result_valid),
    .result        (result)
);

`default_nettype wire

/* src/issue_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_unit import rs_pkg::*; #(
    parameter int rs_depth = 16
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    output logic      rs_full,
    output logic      result_valid,
    output result_t   result
);

    logic [rs_depth-1:0] ready_vec;
    logic [rs_depth-1:0] free_vec;
    logic [rs_depth-1:0] issue_grant;
    logic [rs_depth-1:0] alloc_grant;
    logic                alloc_ok;
    logic                issue_valid;
    issue_t              issue;

    rs_entry_array #(
        .rs_depth(rs_depth)
    ) u_entries (
        .clk           (clk),
        .reset         (reset),
        .dispatch_valid(dispatch_valid),
        .dispatch      (dispatch),
        .alloc_grant   (alloc_grant),
        .issue_grant   (issue_grant),
        .result_valid  (result_valid),   // result bus fed back
        .result        (result),
        .ready_vec     (ready_vec),
        .free_vec      (free_vec),
        .issue_valid   (issue_valid),
        .issue         (issue)
    );

    issue_select #(
        .rs_depth(rs_depth)
    ) u_select (
        .ready_vec  (ready_vec),
        .free_vec   (free_vec),
        .issue_grant(issue_grant),
        .alloc_grant(alloc_grant),
        .alloc_ok   (alloc_ok)
    );

    int_alu u_alu (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .result_valid(result_valid),
        .result      (result)
    );

    assign rs_full = ~alloc_ok;

endmodule

`default_nettype wire

/* src/int_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module int_alu import rs_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    issue_valid,
    input  issue_t  issue,
    output logic    result_valid,
    output result_t result
);

    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] alu_value;
    logic              lt_signed;

    assign op_a      = issue.src1_val;
    assign op_b      = issue.src2_val;
    assign lt_signed = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (issue.op)
            add:     alu_value = op_a + op_b;   // wraps at 32 bits
            sub:     alu_value = op_a - op_b;
            and_op:  alu_value = op_a & op_b;
            or_op:   alu_value = op_a | op_b;
            xor_op:  alu_value = op_a ^ op_b;
            sll:     alu_value = op_a << op_b[4:0];
            srl:     alu_value = op_a >> op_b[4:0];   // logical
            slt:     alu_value = {{(data_w-1){1'b0}}, lt_signed};
            default: alu_value = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue_valid;
        end
    end

    // result bus payload, qualified by result_valid
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            result.tag   <= issue.dest;
            result.value <= alu_value;
        end
    end

endmodule

`default_nettype wire

/* src/issue_select.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_select #(
    parameter int rs_depth = 16
) (
    input  logic [rs_depth-1:0] ready_vec,
    input  logic [rs_depth-1:0] free_vec,
    output logic [rs_depth-1:0] issue_grant,
    output logic [rs_depth-1:0] alloc_grant,
    output logic                alloc_ok
);

    // lowest set bit as a one-hot vector, zero when none set
    function automatic logic [rs_depth-1:0] pick_lowest(
        input logic [rs_depth-1:0] req
    );
        logic [rs_depth-1:0] grant;
        logic                found;
        grant = '0;
        found = 1'b0;
        for (int i = 0; i < rs_depth; i++) begin
            if (req[i] && !found) begin
                grant[i] = 1'b1;
                found    = 1'b1;
            end
        end
        return grant;
    endfunction

    always_comb begin
        issue_grant = pick_lowest(ready_vec);   // oldest slot not implied, index only
        alloc_grant = pick_lowest(free_vec);
        alloc_ok    = |free_vec;
    end

endmodule

`default_nettype wire

/* src/rs_entry_array.sv */
`timescale 1ns/10ps
`default_nettype none

module rs_entry_array import rs_pkg::*; #(
    parameter int rs_depth = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                dispatch_valid,
    input  dispatch_t           dispatch,
    input  logic [rs_depth-1:0] alloc_grant,
    input  logic [rs_depth-1:0] issue_grant,
    input  logic                result_valid,
    input  result_t             result,
    output logic [rs_depth-1:0] ready_vec,
    output logic [rs_depth-1:0] free_vec,
    output logic                issue_valid,
    output issue_t              issue
);

    logic [rs_depth-1:0] busy;
    alu_op_e             op_q     [rs_depth];
    logic [tag_w-1:0]    dest_q   [rs_depth];
    src_operand_t        src1_q   [rs_depth];
    src_operand_t        src2_q   [rs_depth];
    src_operand_t        src1_fwd [rs_depth];   // stored operand seen through the bus
    src_operand_t        src2_fwd [rs_depth];
    issue_t              issue_pick;

    // tag match against the result bus
    function automatic src_operand_t capture(
        input src_operand_t s,
        input logic         rv,
        input result_t      r
    );
        src_operand_t o;
        o = s;
        if (!s.ready && rv && s.tag == r.tag) begin
            o.ready = 1'b1;
            o.data  = r.value;
        end
        return o;
    endfunction

    // wakeup is visible to the select in the same cycle
    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            src1_fwd[i]  = capture(src1_q[i], result_valid, result);
            src2_fwd[i]  = capture(src2_q[i], result_valid, result);
            ready_vec[i] = busy[i] && src1_fwd[i].ready && src2_fwd[i].ready;
        end
    end

    assign free_vec = ~busy;

    // one-hot grant, so an or of the masked entries is enough
    always_comb begin
        issue_pick = '0;
        for (int i = 0; i < rs_depth; i++) begin
            if (issue_grant[i]) begin
                issue_pick.op       = op_q[i];
                issue_pick.dest     = dest_q[i];
                issue_pick.src1_val = src1_fwd[i].data;
                issue_pick.src2_val = src2_fwd[i].data;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy        <= '0;
            issue_valid <= 1'b0;
        end else begin
            busy        <= (busy & ~issue_grant) | (dispatch_valid ? alloc_grant : '0);
            issue_valid <= |issue_grant;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (dispatch_valid && alloc_grant[i]) begin
                op_q[i]   <= dispatch.op;
                dest_q[i] <= dispatch.dest;
                src1_q[i] <= capture(dispatch.src1, result_valid, result);   // bypass
                src2_q[i] <= capture(dispatch.src2, result_valid, result);
            end else if (busy[i]) begin
                src1_q[i] <= src1_fwd[i];
                src2_q[i] <= src2_fwd[i];
            end
        end
        if (|issue_grant) begin
            issue <= issue_pick;
        end
    end

endmodule

`default_nettype wire

/* src/rs_pkg.sv */
`default_nettype none

package rs_pkg;

    localparam int tag_w  = 6;   // 64 physical tags
    localparam int data_w = 32;

    typedef enum logic [2:0] {
        add    = 3'd0,
        sub    = 3'd1,
        and_op = 3'd2,
        or_op  = 3'd3,
        xor_op = 3'd4,
        sll    = 3'd5,
        srl    = 3'd6,
        slt    = 3'd7
    } alu_op_e;

    // data is only meaningful once ready is set
    typedef struct packed {
        logic              ready;
        logic [tag_w-1:0]  tag;   // producer tag while waiting
        logic [data_w-1:0] data;
    } src_operand_t;

    typedef struct packed {
        alu_op_e          op;
        logic [tag_w-1:0] dest;
        src_operand_t     src1;
        src_operand_t     src2;
    } dispatch_t;

    typedef struct packed {
        alu_op_e           op;
        logic [tag_w-1:0]  dest;
        logic [data_w-1:0] src1_val;
        logic [data_w-1:0] src2_val;
    } issue_t;

    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] value;
    } result_t;

endpackage

`default_nettype wire
